// ==== source/scanline_defines.svh ====
/*
  scanline emulator widths, thickness offsets and pipeline depths
*/
`ifndef SCANLINE_DEFINES_SVH
`define SCANLINE_DEFINES_SVH

// video data
`define COLOR_W 8              // bits per color channel
`define STR_W   8              // scanline strength and line position

// distance at which the dark band starts, per thickness
`define SL_OFS_THIN   8'h30
`define SL_OFS_NORMAL 8'h20
`define SL_OFS_THICK  8'h10

`define SL_PROFILE_W  8'h40    // ramp from band edge to full strength

// pipeline depths in clocks
`define CTRL_LAT  5
`define SHADE_LAT 3

`endif

// ==== source/scanline_pkg.sv ====
/*
  scanline emulator types
  color and strength words, thickness and profile selections
*/
`include "scanline_defines.svh"

package scanline_pkg;

  typedef logic [`COLOR_W-1:0] color_t;
  typedef logic [`STR_W-1:0]   strength_t;

  typedef enum logic [1:0] {
    SL_THICK_NONE = 2'd0,  // scanlines off
    SL_THIN       = 2'd1,
    SL_NORMAL     = 2'd2,
    SL_THICK      = 2'd3
  } sl_thick_e;

  typedef enum logic {
    SL_PROF_RECT = 1'b0,   // linear ramp at the band edge
    SL_PROF_FLAT = 1'b1    // hard edge, full strength inside
  } sl_profile_e;

endpackage

// ==== source/sl_profile_ctrl.sv ====
/*
  scanline profile controller
  folds the relative line position, applies thickness and profile and
  scales the result by the user strength
*/
`timescale 1ns/10ps
`include "scanline_defines.svh"

module sl_profile_ctrl import scanline_pkg::*; (
  input  logic              VCLK_i,
  input  logic              nVRST_i,

  input  logic              sl_en_i,
  input  sl_thick_e         sl_thick_i,
  input  sl_profile_e       sl_profile_i,
  input  logic [`STR_W-1:0] sl_rel_pos_i,
  input  strength_t         sl_strength_i,

  output logic              draw_sl_o,
  output strength_t         sl_str_o
);

  localparam logic [`STR_W-1:0] HALF_POS = 1'b1 << (`STR_W-1);

  // settings travel with the pixel
  sl_thick_e   thick_q1;
  sl_profile_e prof_q1;
  sl_profile_e prof_q2;
  logic [4:1]  en_q;
  strength_t   str_q [1:4];

  logic [`STR_W-1:0] dist_q1;   // folded distance to line center
  logic [`STR_W-1:0] d_q2;
  logic [`STR_W-1:0] d_q3;
  logic [`STR_W-1:0] shape_q4;
  logic [4:2]        draw_q;
  logic [4:2]        max_q;

  logic [`STR_W-1:0]   ofs_w;
  logic                thick_on_w;
  logic                top_w;
  logic [2*`STR_W-1:0] scaled_w;

  ////////////////////
  // offset select

  always_comb begin
    thick_on_w = 1'b1;
    case (thick_q1)
      SL_THIN:   ofs_w = `SL_OFS_THIN;
      SL_NORMAL: ofs_w = `SL_OFS_NORMAL;
      SL_THICK:  ofs_w = `SL_OFS_THICK;
      default: begin
        ofs_w      = '0;
        thick_on_w = 1'b0;  // never draws
      end
    endcase
  end

  assign top_w    = |d_q2[`STR_W-1 -: 3];      // beyond the flat-top edge
  assign scaled_w = shape_q4 * str_q[4];

  ////////////////////
  // datapath

  always_ff @(posedge VCLK_i) begin
    // 256 - pos in the lower half of the line
    dist_q1  <= (sl_rel_pos_i > HALF_POS) ? ~sl_rel_pos_i + 1'b1 : sl_rel_pos_i;
    d_q2     <= dist_q1 - ofs_w;
    d_q3     <= d_q2;
    shape_q4 <= {d_q3[5:0], d_q3[5:4]};  // 6 bit ramp stretched to 8 bit
    str_q[1] <= sl_strength_i;
    for (int i = 2; i <= 4; i++) begin
      str_q[i] <= str_q[i-1];
    end
  end

  ////////////////////
  // flags and output

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      thick_q1  <= SL_THICK_NONE;
      prof_q1   <= SL_PROF_RECT;
      prof_q2   <= SL_PROF_RECT;
      en_q      <= '0;
      draw_q    <= '0;
      max_q     <= '0;
      draw_sl_o <= 1'b0;
      sl_str_o  <= '0;
    end else begin
      thick_q1 <= sl_thick_i;
      prof_q1  <= sl_profile_i;
      prof_q2  <= prof_q1;
      en_q     <= {en_q[3:1], sl_en_i};

      draw_q[2] <= thick_on_w && (dist_q1 > ofs_w);
      max_q[2]  <= dist_q1 >= ofs_w + `SL_PROFILE_W;

      if (prof_q2 == SL_PROF_FLAT) begin
        draw_q[3] <= draw_q[2] & top_w;
        max_q[3]  <= top_w;
      end else begin
        draw_q[3] <= draw_q[2];
        max_q[3]  <= max_q[2];
      end

      draw_q[4] <= draw_q[3];
      max_q[4]  <= max_q[3];

      draw_sl_o <= draw_q[4] & en_q[4];
      sl_str_o  <= max_q[4] ? str_q[4] : scaled_w[2*`STR_W-1:`STR_W];  // saturate
    end
  end

  // enable seen at the pixel's sampling edge gates its draw flag
  a_draw_needs_en: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    draw_sl_o |-> $past(sl_en_i, `CTRL_LAT))
    else $error("scanline drawn without enable");

endmodule

// ==== source/video_delay.sv ====
/*
  video delay line
  holds syncs, DE and RGB while the profile controller works
*/
`timescale 1ns/10ps
`include "scanline_defines.svh"

module video_delay import scanline_pkg::*; #(
  parameter int DEPTH = `CTRL_LAT
) (
  input  logic   VCLK_i,
  input  logic   nVRST_i,

  input  logic   hsync_i,
  input  logic   vsync_i,
  input  logic   de_i,
  input  color_t red_i,
  input  color_t green_i,
  input  color_t blue_i,

  output logic   hsync_o,
  output logic   vsync_o,
  output logic   de_o,
  output color_t red_o,
  output color_t green_o,
  output color_t blue_o
);

  logic [2:0] ctl_q [DEPTH];  // {hsync, vsync, de}
  color_t     red_q [DEPTH];
  color_t     green_q [DEPTH];
  color_t     blue_q [DEPTH];

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        ctl_q[i]   <= '0;
        red_q[i]   <= '0;
        green_q[i] <= '0;
        blue_q[i]  <= '0;
      end
    end else begin
      ctl_q[0]   <= {hsync_i, vsync_i, de_i};
      red_q[0]   <= red_i;
      green_q[0] <= green_i;
      blue_q[0]  <= blue_i;
      for (int i = 1; i < DEPTH; i++) begin
        ctl_q[i]   <= ctl_q[i-1];
        red_q[i]   <= red_q[i-1];
        green_q[i] <= green_q[i-1];
        blue_q[i]  <= blue_q[i-1];
      end
    end
  end

  assign {hsync_o, vsync_o, de_o} = ctl_q[DEPTH-1];
  assign red_o   = red_q[DEPTH-1];
  assign green_o = green_q[DEPTH-1];
  assign blue_o  = blue_q[DEPTH-1];

endmodule

// ==== source/sl_pixel_shade.sv ====
/*
  scanline pixel shader
  darkens RGB by the scanline strength inside active video
*/
`timescale 1ns/10ps
`include "scanline_defines.svh"

module sl_pixel_shade import scanline_pkg::*; (
  input  logic      VCLK_i,
  input  logic      nVRST_i,

  input  logic      draw_sl_i,
  input  strength_t sl_str_i,

  input  logic      hsync_i,
  input  logic      vsync_i,
  input  logic      de_i,
  input  color_t    red_i,
  input  color_t    green_i,
  input  color_t    blue_i,

  output logic      hsync_o,
  output logic      vsync_o,
  output logic      de_o,
  output color_t    red_o,
  output color_t    green_o,
  output color_t    blue_o
);

  localparam int CARRY = `SHADE_LAT - 1;  // stages ahead of the output register

  // upper byte of color times factor
  function automatic color_t shade_mul(color_t col, strength_t fac);
    logic [`COLOR_W+`STR_W-1:0] prod;
    prod = col * fac;
    return prod[`COLOR_W+`STR_W-1:`STR_W];
  endfunction

  strength_t        fac_q1;
  color_t           red_sh_q2;
  color_t           green_sh_q2;
  color_t           blue_sh_q2;
  logic [CARRY-1:0] hs_q;
  logic [CARRY-1:0] vs_q;
  logic [CARRY-1:0] de_q;
  logic [CARRY-1:0] draw_q;
  color_t           red_q [CARRY];
  color_t           green_q [CARRY];
  color_t           blue_q [CARRY];

  logic sel_w;

  assign sel_w = de_q[CARRY-1] & draw_q[CARRY-1];

  ////////////////////
  // invert and multiply

  always_ff @(posedge VCLK_i) begin
    fac_q1      <= {`STR_W{1'b1}} - sl_str_i;
    red_sh_q2   <= shade_mul(red_q[0], fac_q1);
    green_sh_q2 <= shade_mul(green_q[0], fac_q1);
    blue_sh_q2  <= shade_mul(blue_q[0], fac_q1);
    red_q[0]    <= red_i;   // original pixel kept for bypass
    green_q[0]  <= green_i;
    blue_q[0]   <= blue_i;
    for (int i = 1; i < CARRY; i++) begin
      red_q[i]   <= red_q[i-1];
      green_q[i] <= green_q[i-1];
      blue_q[i]  <= blue_q[i-1];
    end
  end

  ////////////////////
  // select and output

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      {hs_q, vs_q, de_q, draw_q} <= '0;
      {hsync_o, vsync_o, de_o}   <= '0;
      red_o   <= '0;
      green_o <= '0;
      blue_o  <= '0;
    end else begin
      hs_q    <= {hs_q[CARRY-2:0], hsync_i};
      vs_q    <= {vs_q[CARRY-2:0], vsync_i};
      de_q    <= {de_q[CARRY-2:0], de_i};
      draw_q  <= {draw_q[CARRY-2:0], draw_sl_i};
      hsync_o <= hs_q[CARRY-1];
      vsync_o <= vs_q[CARRY-1];
      de_o    <= de_q[CARRY-1];
      red_o   <= sel_w ? red_sh_q2 : red_q[CARRY-1];
      green_o <= sel_w ? green_sh_q2 : green_q[CARRY-1];
      blue_o  <= sel_w ? blue_sh_q2 : blue_q[CARRY-1];
    end
  end

  // a pixel is never brighter than the one that entered SHADE_LAT clocks ago
  a_never_brighter: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (red_o <= $past(red_i, `SHADE_LAT)) && (green_o <= $past(green_i, `SHADE_LAT)) &&
    (blue_o <= $past(blue_i, `SHADE_LAT)))
    else $error("shaded pixel brighter than its source");

endmodule

// ==== source/scanline_emu.sv ====
/*
  scanline emulator top
  profile controller and video delay feed the pixel shader
*/
`timescale 1ns/10ps
`include "scanline_defines.svh"

module scanline_emu import scanline_pkg::*; (
  input  logic              VCLK_i,
  input  logic              nVRST_i,

  input  logic              hsync_i,
  input  logic              vsync_i,
  input  logic              de_i,
  input  color_t            red_i,
  input  color_t            green_i,
  input  color_t            blue_i,

  input  logic              sl_en_i,
  input  sl_thick_e         sl_thick_i,
  input  sl_profile_e       sl_profile_i,
  input  logic [`STR_W-1:0] sl_rel_pos_i,  // position within the line pair
  input  strength_t         sl_strength_i,

  output logic              hsync_o,
  output logic              vsync_o,
  output logic              de_o,
  output color_t            red_o,
  output color_t            green_o,
  output color_t            blue_o
);

  logic      draw_sl_w;
  strength_t sl_str_w;

  // video aligned to the controller result
  logic      dly_hs_w;
  logic      dly_vs_w;
  logic      dly_de_w;
  color_t    dly_red_w;
  color_t    dly_green_w;
  color_t    dly_blue_w;

  sl_profile_ctrl ctrl0 (
    .VCLK_i        (VCLK_i),
    .nVRST_i       (nVRST_i),
    .sl_en_i       (sl_en_i),
    .sl_thick_i    (sl_thick_i),
    .sl_profile_i  (sl_profile_i),
    .sl_rel_pos_i  (sl_rel_pos_i),
    .sl_strength_i (sl_strength_i),
    .draw_sl_o     (draw_sl_w),
    .sl_str_o      (sl_str_w)
  );

  video_delay #(
    .DEPTH (`CTRL_LAT)
  ) dly0 (
    .VCLK_i  (VCLK_i),
    .nVRST_i (nVRST_i),
    .hsync_i (hsync_i),
    .vsync_i (vsync_i),
    .de_i    (de_i),
    .red_i   (red_i),
    .green_i (green_i),
    .blue_i  (blue_i),
    .hsync_o (dly_hs_w),
    .vsync_o (dly_vs_w),
    .de_o    (dly_de_w),
    .red_o   (dly_red_w),
    .green_o (dly_green_w),
    .blue_o  (dly_blue_w)
  );

  sl_pixel_shade shade0 (
    .VCLK_i    (VCLK_i),
    .nVRST_i   (nVRST_i),
    .draw_sl_i (draw_sl_w),
    .sl_str_i  (sl_str_w),
    .hsync_i   (dly_hs_w),
    .vsync_i   (dly_vs_w),
    .de_i      (dly_de_w),
    .red_i     (dly_red_w),
    .green_i   (dly_green_w),
    .blue_i    (dly_blue_w),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o),
    .de_o      (de_o),
    .red_o     (red_o),
    .green_o   (green_o),
    .blue_o    (blue_o)
  );

endmodule

// ==== verification/tb_scanline_emu.sv ====
/*
  testbench for the scanline emulator
  sweeps line positions under several settings, checks against a reference model
*/
`timescale 1ns/10ps
`include "scanline_defines.svh"

module tb_scanline_emu import scanline_pkg::*; ();

  localparam int LAT      = 8;    // input edge to output edge
  localparam int GAP      = 16;   // blank cycles per line
  localparam int LINE_LEN = GAP + 256;
  localparam int N_LINES  = 9;
  localparam int LIMIT    = N_LINES * LINE_LEN + LAT + 200;

  logic        VCLK_i;
  logic        nVRST_i;
  logic        hsync_i, vsync_i, de_i;
  color_t      red_i, green_i, blue_i;
  logic        sl_en_i;
  sl_thick_e   sl_thick_i;
  sl_profile_e sl_profile_i;
  logic [7:0]  sl_rel_pos_i;
  strength_t   sl_strength_i;
  logic        hsync_o, vsync_o, de_o;
  color_t      red_o, green_o, blue_o;

  logic [31:0] seed = 32'h45b7;
  string       test_name = "reset";
  int          err_sync = 0;
  int          err_color = 0;
  int          cycle_cnt = 0;

  // expected outputs with the oldest at index 7
  logic [2:0]  exp_ctl [8];
  color_t      exp_red [8];
  color_t      exp_green [8];
  color_t      exp_blue [8];
  string       exp_name [8];

  scanline_emu dut0 (
    .VCLK_i        (VCLK_i),
    .nVRST_i       (nVRST_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .de_i          (de_i),
    .red_i         (red_i),
    .green_i       (green_i),
    .blue_i        (blue_i),
    .sl_en_i       (sl_en_i),
    .sl_thick_i    (sl_thick_i),
    .sl_profile_i  (sl_profile_i),
    .sl_rel_pos_i  (sl_rel_pos_i),
    .sl_strength_i (sl_strength_i),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .de_o          (de_o),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o)
  );

  initial begin
    VCLK_i = 1'b0;
    forever #2 VCLK_i = ~VCLK_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // {draw, strength} from position and settings
  function automatic logic [8:0] band_strength(input logic en, input sl_thick_e th,
                                               input sl_profile_e pr, input logic [7:0] pos,
                                               input strength_t st);
    logic [7:0]  p;
    logic [7:0]  ofs;
    logic [7:0]  d;
    logic [7:0]  shape;
    logic [15:0] prod;
    logic        draw;
    logic        max;
    p = (pos > 8'h80) ? 8'(9'd256 - pos) : pos;
    case (th)
      SL_THIN:   ofs = 8'h30;
      SL_NORMAL: ofs = 8'h20;
      SL_THICK:  ofs = 8'h10;
      default:   ofs = 8'h00;
    endcase
    d    = p - ofs;
    draw = (th != SL_THICK_NONE) && (p > ofs);
    max  = p >= ofs + 8'h40;
    if (pr == SL_PROF_FLAT) begin
      draw = draw && (d[7:5] != 3'b000);
      max  = d[7:5] != 3'b000;
    end
    shape = {d[5:0], d[5:4]};
    prod  = shape * st;
    return {draw && en, max ? st : prod[15:8]};
  endfunction

  function automatic color_t darken(input color_t c, input strength_t s);
    logic [15:0] prod;
    prod = c * (8'hff - s);
    return prod[15:8];
  endfunction

  ////////////////////
  // reference model

  always @(posedge VCLK_i or negedge nVRST_i) begin
    logic [8:0] ds;
    logic       sel;
    if (!nVRST_i) begin
      for (int i = 0; i < 8; i++) begin
        exp_ctl[i]   <= '0;
        exp_red[i]   <= '0;
        exp_green[i] <= '0;
        exp_blue[i]  <= '0;
        exp_name[i]  <= "reset";
      end
    end else begin
      ds  = band_strength(sl_en_i, sl_thick_i, sl_profile_i, sl_rel_pos_i, sl_strength_i);
      sel = ds[8] && de_i;
      exp_ctl[0]   <= {hsync_i, vsync_i, de_i};
      exp_red[0]   <= sel ? darken(red_i, ds[7:0]) : red_i;
      exp_green[0] <= sel ? darken(green_i, ds[7:0]) : green_i;
      exp_blue[0]  <= sel ? darken(blue_i, ds[7:0]) : blue_i;
      exp_name[0]  <= test_name;
      for (int i = 1; i < 8; i++) begin
        exp_ctl[i]   <= exp_ctl[i-1];
        exp_red[i]   <= exp_red[i-1];
        exp_green[i] <= exp_green[i-1];
        exp_blue[i]  <= exp_blue[i-1];
        exp_name[i]  <= exp_name[i-1];
      end
    end
  end

  ////////////////////
  // checks

  a_reset_zero: assert property (@(posedge VCLK_i)
    $rose(nVRST_i) |-> ({hsync_o, vsync_o, de_o} == 3'b000 && red_o == 0 &&
                        green_o == 0 && blue_o == 0))
    else begin
      err_sync++;
      $display("outputs are not zero right after reset");
    end

  a_sync: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    {hsync_o, vsync_o, de_o} == exp_ctl[7])
    else begin
      err_sync++;
      $display("ERROR %s sync/de expected %b actual %b", exp_name[7],
               $sampled(exp_ctl[7]), $sampled({hsync_o, vsync_o, de_o}));
    end

  a_red: assert property (@(posedge VCLK_i) disable iff (!nVRST_i) red_o == exp_red[7])
    else begin
      err_color++;
      $display("ERROR %s red expected %h actual %h", exp_name[7],
               $sampled(exp_red[7]), $sampled(red_o));
    end

  a_green: assert property (@(posedge VCLK_i) disable iff (!nVRST_i) green_o == exp_green[7])
    else begin
      err_color++;
      $display("ERROR %s green expected %h actual %h", exp_name[7],
               $sampled(exp_green[7]), $sampled(green_o));
    end

  a_blue: assert property (@(posedge VCLK_i) disable iff (!nVRST_i) blue_o == exp_blue[7])
    else begin
      err_color++;
      $display("ERROR %s blue expected %h actual %h", exp_name[7],
               $sampled(exp_blue[7]), $sampled(blue_o));
    end

  always @(posedge VCLK_i) begin
    cycle_cnt++;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus

  task automatic next_pixel();
    seed = lcg_next(seed);
    red_i   = seed[31:24];
    green_i = seed[23:16];
    blue_i  = seed[15:8];
  endtask

  // blank gap with new settings, then one full position sweep
  task automatic run_line(input string name, input logic en, input sl_thick_e th,
                          input sl_profile_e pr, input strength_t st, input logic vs);
    for (int i = 0; i < GAP; i++) begin
      @(negedge VCLK_i);
      if (i == 0) begin
        test_name     = name;
        sl_en_i       = en;
        sl_thick_i    = th;
        sl_profile_i  = pr;
        sl_strength_i = st;
      end
      de_i         = 1'b0;
      hsync_i      = (i < 4);   // sync pulse at the start of blanking
      vsync_i      = vs;
      sl_rel_pos_i = 8'(i * 16);
      next_pixel();
    end
    for (int i = 0; i < 256; i++) begin
      @(negedge VCLK_i);
      de_i         = 1'b1;
      hsync_i      = 1'b0;
      vsync_i      = 1'b0;
      sl_rel_pos_i = 8'(i);
      next_pixel();
    end
  endtask

  initial begin
    nVRST_i       = 1'b0;
    hsync_i       = 1'b0;
    vsync_i       = 1'b0;
    de_i          = 1'b0;
    red_i         = '0;
    green_i       = '0;
    blue_i        = '0;
    sl_en_i       = 1'b0;
    sl_thick_i    = SL_THICK_NONE;
    sl_profile_i  = SL_PROF_RECT;
    sl_rel_pos_i  = '0;
    sl_strength_i = '0;

    repeat (3) @(negedge VCLK_i);
    nVRST_i = 1'b1;

    run_line("disabled",     1'b0, SL_NORMAL,     SL_PROF_RECT, 8'h80, 1'b1);
    run_line("thick_none",   1'b1, SL_THICK_NONE, SL_PROF_RECT, 8'h80, 1'b0);
    run_line("rect_thin",    1'b1, SL_THIN,       SL_PROF_RECT, 8'h9c, 1'b0);
    run_line("rect_normal",  1'b1, SL_NORMAL,     SL_PROF_RECT, 8'h5a, 1'b0);
    run_line("rect_thick",   1'b1, SL_THICK,      SL_PROF_RECT, 8'hc8, 1'b0);
    run_line("flat_normal",  1'b1, SL_NORMAL,     SL_PROF_FLAT, 8'h70, 1'b0);
    run_line("flat_thick",   1'b1, SL_THICK,      SL_PROF_FLAT, 8'ha0, 1'b0);
    run_line("strength_min", 1'b1, SL_NORMAL,     SL_PROF_RECT, 8'h00, 1'b0);
    run_line("strength_max", 1'b1, SL_THIN,       SL_PROF_RECT, 8'hff, 1'b0);

    // drain the pipeline
    for (int i = 0; i < LAT + 4; i++) begin
      @(negedge VCLK_i);
      de_i = 1'b0;
    end

    $display("errors: sync %0d color %0d", err_sync, err_color);
    if (err_sync + err_color == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+source
source/scanline_pkg.sv
source/sl_profile_ctrl.sv
source/video_delay.sv
source/sl_pixel_shade.sv
source/scanline_emu.sv
verification/tb_scanline_emu.sv

// ==== Makefile ====
# Verilator build for the scanline emulator

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert +incdir+source \
	  source/scanline_pkg.sv source/sl_profile_ctrl.sv source/video_delay.sv \
	  source/sl_pixel_shade.sv source/scanline_emu.sv --top-module scanline_emu

sim:
	verilator --binary --timing --assert -f flist.f \
	  --top-module tb_scanline_emu -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_scanline_emu | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
